//--- hw/cpu_pkg.sv
package cpu_pkg;

  // datapath widths
  localparam int data_w     = 16;
  localparam int instr_w    = 16;
  localparam int reg_addr_w = 3;
  localparam int imm_w      = 6;
  localparam int apb_addr_w = 12;

  // opcodes
  localparam logic [3:0] op_alu  = 4'h0;
  localparam logic [3:0] op_addi = 4'h1;
  localparam logic [3:0] op_lw   = 4'h2;
  localparam logic [3:0] op_sw   = 4'h3;
  localparam logic [3:0] op_beq  = 4'h4;
  localparam logic [3:0] op_bne  = 4'h5;
  localparam logic [3:0] op_halt = 4'hf;

  // R-form function codes, shifts take the low 4 bits of rt
  localparam logic [2:0] fn_add = 3'd0;
  localparam logic [2:0] fn_sub = 3'd1;
  localparam logic [2:0] fn_and = 3'd2;
  localparam logic [2:0] fn_or  = 3'd3;
  localparam logic [2:0] fn_xor = 3'd4;
  localparam logic [2:0] fn_slt = 3'd5;
  localparam logic [2:0] fn_shl = 3'd6;
  localparam logic [2:0] fn_shr = 3'd7;

  // host register map, byte addresses
  localparam logic [apb_addr_w-1:0] addr_prog_base = 12'h000;
  localparam logic [apb_addr_w-1:0] addr_ctrl      = 12'h400;
  localparam logic [apb_addr_w-1:0] addr_retired   = 12'h404;

  // one instruction word, two decodings
  // sw: rd is the data register
  // beq/bne: rd and rs compared, imm is a word offset from pc + 1
  typedef union packed {
    struct packed {
      logic [3:0]            opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [2:0]            funct;
    } r_form;
    struct packed {
      logic [3:0]            opcode;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs;
      logic [imm_w-1:0]      imm;
    } i_form;
  } instr_t;

endpackage

//--- hw/apb_ctrl.sv
module apb_ctrl #(
  parameter int imem_depth = 64
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [cpu_pkg::apb_addr_w-1:0]    paddr,
  input  logic [cpu_pkg::data_w-1:0]        pwdata,
  input  logic                              retire,
  input  logic                              halt_seen,
  output logic [cpu_pkg::data_w-1:0]        prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              imem_we,
  output logic [$clog2(imem_depth)-1:0]     imem_addr,
  output logic [cpu_pkg::instr_w-1:0]       imem_wdata,
  output logic                              run,
  output logic                              start
);

  logic                      wr_acc;
  logic                      rd_acc;
  logic                      prog_hit;
  logic                      ctrl_hit;
  logic                      ret_hit;
  logic                      halted;
  logic [cpu_pkg::data_w-1:0] retired;

  // access phase only, no wait states
  assign wr_acc = psel && penable && pwrite;
  assign rd_acc = psel && penable && !pwrite;
  assign pready = 1'b1;

  // address decode
  assign prog_hit = (paddr[1:0] == 2'b00) &&
                    (paddr[cpu_pkg::apb_addr_w-1:2] < imem_depth);
  assign ctrl_hit = (paddr == cpu_pkg::addr_ctrl);
  assign ret_hit  = (paddr == cpu_pkg::addr_retired);

  // program loading, only while stopped
  assign imem_we    = wr_acc && prog_hit && !run;
  assign imem_addr  = paddr[2 +: $clog2(imem_depth)];
  assign imem_wdata = pwdata;

  assign start = wr_acc && ctrl_hit && pwdata[0];

  assign pslverr = (wr_acc && !(ctrl_hit || (prog_hit && !run))) ||
                   (rd_acc && !(ctrl_hit || ret_hit));

  always_comb begin
    prdata = '0;
    if (rd_acc && ctrl_hit) begin
      prdata[1:0] = {halted, run};
    end else if (rd_acc && ret_hit) begin
      prdata = retired;
    end
  end

  //////////////////////////////
  // run control and counters
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run     <= 1'b0;
      halted  <= 1'b0;
      retired <= '0;
    end else if (start) begin
      run     <= 1'b1;
      halted  <= 1'b0;
      retired <= '0;
    end else begin
      // host writing 0 stops the core
      if (wr_acc && ctrl_hit) begin
        run <= 1'b0;
      end else if (halt_seen) begin
        run    <= 1'b0;
        halted <= 1'b1;
      end
      if (retire) begin
        retired <= retired + 1'b1;
      end
    end
  end

  apb_penable_psel: assert property (@(posedge clk) disable iff (!arst_n) penable |-> psel);

endmodule

//--- hw/register_file.sv
module register_file (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_a,
  input  logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_b,
  input  logic                            wr_en,
  input  logic [cpu_pkg::reg_addr_w-1:0]  wr_reg,
  input  logic [cpu_pkg::data_w-1:0]      wr_data,
  output logic [cpu_pkg::data_w-1:0]      rd_data_a,
  output logic [cpu_pkg::data_w-1:0]      rd_data_b
);

  logic [cpu_pkg::data_w-1:0] regs [1:7];
  logic                       wr_live;

  // r0 never takes a write
  assign wr_live = wr_en && (wr_reg != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_reg] <= wr_data;
    end
  end

  // write-through, same-cycle write wins
  assign rd_data_a = (rd_reg_a == '0) ? '0 :
                     (wr_live && wr_reg == rd_reg_a) ? wr_data : regs[rd_reg_a];
  assign rd_data_b = (rd_reg_b == '0) ? '0 :
                     (wr_live && wr_reg == rd_reg_b) ? wr_data : regs[rd_reg_b];

endmodule

//--- hw/decode_stage.sv
module decode_stage #(
  parameter int imem_depth = 64
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            run,
  input  logic                            start,
  input  logic                            imem_we,
  input  logic [$clog2(imem_depth)-1:0]   imem_addr,
  input  logic [cpu_pkg::instr_w-1:0]     imem_wdata,
  input  logic                            redirect,
  input  logic [cpu_pkg::data_w-1:0]      redirect_pc,
  input  logic [cpu_pkg::data_w-1:0]      rd_data_a,
  input  logic [cpu_pkg::data_w-1:0]      rd_data_b,
  output logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_a,
  output logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_b,
  output logic                            de_valid,
  output logic [3:0]                      de_op,
  output logic [2:0]                      de_funct,
  output logic [cpu_pkg::reg_addr_w-1:0]  de_rd,
  output logic [cpu_pkg::reg_addr_w-1:0]  de_rs,
  output logic [cpu_pkg::reg_addr_w-1:0]  de_rt,
  output logic [cpu_pkg::data_w-1:0]      de_a,
  output logic [cpu_pkg::data_w-1:0]      de_b,
  output logic [cpu_pkg::data_w-1:0]      de_imm,
  output logic [cpu_pkg::data_w-1:0]      de_pc
);

  localparam int aw = $clog2(imem_depth);

  logic [cpu_pkg::instr_w-1:0] imem [imem_depth];
  logic [cpu_pkg::data_w-1:0]  pc;
  logic                        halt_pending;
  logic                        issue;
  logic                        is_halt;
  cpu_pkg::instr_t             iw;

  // instruction memory, loaded from the host
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign iw      = imem[pc[aw-1:0]];
  assign is_halt = (iw.i_form.opcode == cpu_pkg::op_halt);

  // second read port is rt for R forms, rd for stores and branches
  assign rd_reg_a = iw.r_form.rs;
  assign rd_reg_b = (iw.r_form.opcode == cpu_pkg::op_alu) ? iw.r_form.rt : iw.i_form.rd;

  // taken branch kills this slot
  assign issue = run && !halt_pending && !redirect;

  //////////////////////////////
  // program counter
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc           <= '0;
      halt_pending <= 1'b0;
    end else if (start) begin
      pc           <= '0;
      halt_pending <= 1'b0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (issue) begin
      // halt parks the pc, bubbles follow
      if (is_halt) begin
        halt_pending <= 1'b1;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      de_valid <= 1'b0;
    end else begin
      de_valid <= issue;
    end
  end

  // decode/execute payload
  always_ff @(posedge clk) begin
    de_op    <= iw.r_form.opcode;
    de_funct <= iw.r_form.funct;
    de_rd    <= iw.r_form.rd;
    de_rs    <= rd_reg_a;
    de_rt    <= rd_reg_b;
    de_a     <= rd_data_a;
    de_b     <= rd_data_b;
    de_imm   <= {{(cpu_pkg::data_w - cpu_pkg::imm_w){iw.i_form.imm[cpu_pkg::imm_w-1]}},
                 iw.i_form.imm};
    de_pc    <= pc;
  end

  pc_in_range: assert property (@(posedge clk) disable iff (!arst_n) run |-> pc < imem_depth);

endmodule

//--- hw/execute_stage.sv
module execute_stage (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            de_valid,
  input  logic [3:0]                      de_op,
  input  logic [2:0]                      de_funct,
  input  logic [cpu_pkg::reg_addr_w-1:0]  de_rd,
  input  logic [cpu_pkg::reg_addr_w-1:0]  de_rs,
  input  logic [cpu_pkg::reg_addr_w-1:0]  de_rt,
  input  logic [cpu_pkg::data_w-1:0]      de_a,
  input  logic [cpu_pkg::data_w-1:0]      de_b,
  input  logic [cpu_pkg::data_w-1:0]      de_imm,
  input  logic [cpu_pkg::data_w-1:0]      de_pc,
  input  logic                            wr_en,
  input  logic [cpu_pkg::reg_addr_w-1:0]  wr_reg,
  input  logic [cpu_pkg::data_w-1:0]      wr_data,
  output logic                            redirect,
  output logic [cpu_pkg::data_w-1:0]      redirect_pc,
  output logic                            ex_valid,
  output logic [3:0]                      ex_op,
  output logic [cpu_pkg::reg_addr_w-1:0]  ex_rd,
  output logic [cpu_pkg::data_w-1:0]      ex_value,
  output logic [cpu_pkg::data_w-1:0]      ex_store_data,
  output logic                            ex_writes
);

  logic [cpu_pkg::data_w-1:0] a;
  logic [cpu_pkg::data_w-1:0] b;
  logic [cpu_pkg::data_w-1:0] alu_y;
  logic [cpu_pkg::data_w-1:0] value;
  logic                       writes;

  // forward from the result stage
  assign a = (wr_en && wr_reg != '0 && wr_reg == de_rs) ? wr_data : de_a;
  assign b = (wr_en && wr_reg != '0 && wr_reg == de_rt) ? wr_data : de_b;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (de_funct)
      cpu_pkg::fn_add: alu_y = a + b;
      cpu_pkg::fn_sub: alu_y = a - b;
      cpu_pkg::fn_and: alu_y = a & b;
      cpu_pkg::fn_or:  alu_y = a | b;
      cpu_pkg::fn_xor: alu_y = a ^ b;
      cpu_pkg::fn_slt: alu_y = {{(cpu_pkg::data_w - 1){1'b0}}, $signed(a) < $signed(b)};
      cpu_pkg::fn_shl: alu_y = a << b[3:0];
      cpu_pkg::fn_shr: alu_y = a >> b[3:0];
      default:         alu_y = '0;
    endcase
  end

  // addi, lw and sw all use rs + imm
  assign value = (de_op == cpu_pkg::op_alu) ? alu_y : a + de_imm;

  assign writes = (de_op == cpu_pkg::op_alu) || (de_op == cpu_pkg::op_addi) ||
                  (de_op == cpu_pkg::op_lw);

  // branch resolution
  assign redirect    = de_valid && (((de_op == cpu_pkg::op_beq) && (a == b)) ||
                                    ((de_op == cpu_pkg::op_bne) && (a != b)));
  assign redirect_pc = de_pc + 1'b1 + de_imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= de_valid;
    end
  end

  // execute/result payload
  always_ff @(posedge clk) begin
    ex_op         <= de_op;
    ex_rd         <= de_rd;
    ex_value      <= value;
    ex_store_data <= b;
    ex_writes     <= writes;
  end

  // the slot behind a taken branch arrives empty
  branch_kills_shadow: assert property (
    @(posedge clk) disable iff (!arst_n) redirect |=> !de_valid
  );

endmodule

//--- hw/result_stage.sv
module result_stage #(
  parameter int dmem_depth = 32
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            ex_valid,
  input  logic [3:0]                      ex_op,
  input  logic [cpu_pkg::reg_addr_w-1:0]  ex_rd,
  input  logic [cpu_pkg::data_w-1:0]      ex_value,
  input  logic [cpu_pkg::data_w-1:0]      ex_store_data,
  input  logic                            ex_writes,
  output logic                            wr_en,
  output logic [cpu_pkg::reg_addr_w-1:0]  wr_reg,
  output logic [cpu_pkg::data_w-1:0]      wr_data,
  output logic                            retire,
  output logic                            halt_seen,
  output logic                            wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0]  wb_reg,
  output logic [cpu_pkg::data_w-1:0]      wb_data,
  output logic                            st_valid,
  output logic [cpu_pkg::data_w-1:0]      st_addr,
  output logic [cpu_pkg::data_w-1:0]      st_data
);

  localparam int aw = $clog2(dmem_depth);

  logic [cpu_pkg::data_w-1:0] dmem [dmem_depth];
  logic [aw-1:0]              daddr;
  logic                       store;

  assign daddr = ex_value[aw-1:0];
  assign store = ex_valid && (ex_op == cpu_pkg::op_sw);

  always_ff @(posedge clk) begin
    if (store) begin
      dmem[daddr] <= ex_store_data;
    end
  end

  // writeback select
  assign wr_en   = ex_valid && ex_writes;
  assign wr_reg  = ex_rd;
  assign wr_data = (ex_op == cpu_pkg::op_lw) ? dmem[daddr] : ex_value;

  assign retire    = ex_valid;
  assign halt_seen = ex_valid && (ex_op == cpu_pkg::op_halt);

  // trace port
  assign wb_valid = wr_en;
  assign wb_reg   = wr_reg;
  assign wb_data  = wr_data;
  assign st_valid = store;
  assign st_addr  = ex_value;
  assign st_data  = ex_store_data;

  // decode stops issuing after a halt
  halt_drains: assert property (@(posedge clk) disable iff (!arst_n) halt_seen |=> !ex_valid);

endmodule

//--- hw/cpu_top.sv
module cpu_top #(
  parameter int imem_depth = 64,
  parameter int dmem_depth = 32
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [cpu_pkg::apb_addr_w-1:0]  paddr,
  input  logic [cpu_pkg::data_w-1:0]      pwdata,
  output logic [cpu_pkg::data_w-1:0]      prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0]  wb_reg,
  output logic [cpu_pkg::data_w-1:0]      wb_data,
  output logic                            st_valid,
  output logic [cpu_pkg::data_w-1:0]      st_addr,
  output logic [cpu_pkg::data_w-1:0]      st_data
);

  // host side
  logic                            imem_we;
  logic [$clog2(imem_depth)-1:0]   imem_addr;
  logic [cpu_pkg::instr_w-1:0]     imem_wdata;
  logic                            run;
  logic                            start;
  logic                            retire;
  logic                            halt_seen;

  // register file
  logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_a;
  logic [cpu_pkg::reg_addr_w-1:0]  rd_reg_b;
  logic [cpu_pkg::data_w-1:0]      rd_data_a;
  logic [cpu_pkg::data_w-1:0]      rd_data_b;
  logic                            wr_en;
  logic [cpu_pkg::reg_addr_w-1:0]  wr_reg;
  logic [cpu_pkg::data_w-1:0]      wr_data;

  // decode to execute
  logic                            de_valid;
  logic [3:0]                      de_op;
  logic [2:0]                      de_funct;
  logic [cpu_pkg::reg_addr_w-1:0]  de_rd;
  logic [cpu_pkg::reg_addr_w-1:0]  de_rs;
  logic [cpu_pkg::reg_addr_w-1:0]  de_rt;
  logic [cpu_pkg::data_w-1:0]      de_a;
  logic [cpu_pkg::data_w-1:0]      de_b;
  logic [cpu_pkg::data_w-1:0]      de_imm;
  logic [cpu_pkg::data_w-1:0]      de_pc;

  // execute to decode and result
  logic                            redirect;
  logic [cpu_pkg::data_w-1:0]      redirect_pc;
  logic                            ex_valid;
  logic [3:0]                      ex_op;
  logic [cpu_pkg::reg_addr_w-1:0]  ex_rd;
  logic [cpu_pkg::data_w-1:0]      ex_value;
  logic [cpu_pkg::data_w-1:0]      ex_store_data;
  logic                            ex_writes;

  apb_ctrl #(.imem_depth(imem_depth)) host (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .retire, .halt_seen, .prdata, .pready, .pslverr,
    .imem_we, .imem_addr, .imem_wdata, .run, .start
  );

  register_file regfile (
    .clk, .arst_n, .rd_reg_a, .rd_reg_b, .wr_en, .wr_reg, .wr_data,
    .rd_data_a, .rd_data_b
  );

  decode_stage #(.imem_depth(imem_depth)) decode (
    .clk, .arst_n, .run, .start, .imem_we, .imem_addr, .imem_wdata,
    .redirect, .redirect_pc, .rd_data_a, .rd_data_b, .rd_reg_a, .rd_reg_b,
    .de_valid, .de_op, .de_funct, .de_rd, .de_rs, .de_rt,
    .de_a, .de_b, .de_imm, .de_pc
  );

  execute_stage execute (
    .clk, .arst_n, .de_valid, .de_op, .de_funct, .de_rd, .de_rs, .de_rt,
    .de_a, .de_b, .de_imm, .de_pc, .wr_en, .wr_reg, .wr_data,
    .redirect, .redirect_pc, .ex_valid, .ex_op, .ex_rd,
    .ex_value, .ex_store_data, .ex_writes
  );

  result_stage #(.dmem_depth(dmem_depth)) result (
    .clk, .arst_n, .ex_valid, .ex_op, .ex_rd, .ex_value, .ex_store_data,
    .ex_writes, .wr_en, .wr_reg, .wr_data, .retire, .halt_seen,
    .wb_valid, .wb_reg, .wb_data, .st_valid, .st_addr, .st_data
  );

endmodule

//--- tb/cpu_model.sv
package cpu_model;

  localparam int prog_len   = 40;
  localparam int dmem_words = 32;

  // program image and architectural state, kept across programs
  logic [15:0] prog [prog_len];
  logic [15:0] regs [8];
  logic [15:0] mem [dmem_words];
  logic [4:0]  stored [$];

  // expected trace, {reg, data} and {addr, data}
  logic [18:0] exp_wb [$];
  logic [31:0] exp_st [$];
  int          exp_retired;

  function automatic void reset_model();
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    stored.delete();
  endfunction

  function automatic logic [15:0] sext(logic [5:0] v);
    return {{10{v[5]}}, v};
  endfunction

  function automatic logic [15:0] alu(logic [2:0] fn, logic [15:0] a, logic [15:0] b);
    case (fn)
      cpu_pkg::fn_add: return a + b;
      cpu_pkg::fn_sub: return a - b;
      cpu_pkg::fn_and: return a & b;
      cpu_pkg::fn_or:  return a | b;
      cpu_pkg::fn_xor: return a ^ b;
      cpu_pkg::fn_slt: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
      cpu_pkg::fn_shl: return a << b[3:0];
      default:         return a >> b[3:0];
    endcase
  endfunction

  // r0 writes still show on the trace
  function automatic void expect_write(logic [2:0] rd, logic [15:0] value);
    exp_wb.push_back({rd, value});
    if (rd != 3'd0) begin
      regs[rd] = value;
    end
  endfunction

  //////////////////////////////
  // build one program and run it
  //////////////////////////////
  function automatic void make_program();
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [2:0]  fn;
    logic [5:0]  imm;
    logic [4:0]  slot;
    logic [15:0] addr;
    int          kind;
    int          span;
    int          skip_to;

    exp_wb.delete();
    exp_st.delete();
    exp_retired = 0;
    skip_to     = 0;
    for (int pc = 0; pc < prog_len - 1; pc++) begin
      rd   = 3'($urandom);
      rs   = 3'($urandom);
      rt   = 3'($urandom);
      fn   = 3'($urandom);
      imm  = 6'($urandom);
      kind = $urandom % 10;
      if (pc < skip_to) begin
        // branch shadow, never executed
        prog[pc] = {cpu_pkg::op_alu, rd, rs, rt, fn};
        continue;
      end
      if (kind == 7 && stored.size() == 0) begin
        kind = 0;
      end
      exp_retired++;
      case (kind)
        0, 1, 2, 3: begin
          prog[pc] = {cpu_pkg::op_alu, rd, rs, rt, fn};
          expect_write(rd, alu(fn, regs[rs], regs[rt]));
        end
        4, 5: begin
          prog[pc] = {cpu_pkg::op_addi, rd, rs, imm};
          expect_write(rd, regs[rs] + sext(imm));
        end
        6: begin
          prog[pc] = {cpu_pkg::op_sw, rd, rs, imm};
          addr = regs[rs] + sext(imm);
          exp_st.push_back({addr, regs[rd]});
          mem[addr[4:0]] = regs[rd];
          stored.push_back(addr[4:0]);
        end
        7: begin
          // pick a stored word, reach it from whatever rs holds
          slot = stored[$urandom % stored.size()];
          imm  = {1'b0, slot - regs[rs][4:0]};
          prog[pc] = {cpu_pkg::op_lw, rd, rs, imm};
          expect_write(rd, mem[slot]);
        end
        default: begin
          if (kind == 8) begin
            rd = rs;
          end
          span = (prog_len - 2 - pc > 7) ? 7 : prog_len - 2 - pc;
          imm  = 6'($urandom % (span + 1));
          prog[pc] = {fn[0] ? cpu_pkg::op_bne : cpu_pkg::op_beq, rd, rs, imm};
          if ((regs[rs] == regs[rd]) != fn[0]) begin
            skip_to = pc + 1 + int'(imm);
          end
        end
      endcase
    end
    prog[prog_len-1] = {cpu_pkg::op_halt, 12'd0};
    exp_retired++;
  endfunction

endpackage

//--- tb/cpu_tb.sv
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_progs     = 8;
  localparam int cycle_limit = n_progs * (cpu_model::prog_len * 2 + 200 + 100);

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        wb_valid;
  logic [2:0]  wb_reg;
  logic [15:0] wb_data;
  logic        st_valid;
  logic [15:0] st_addr;
  logic [15:0] st_data;
  int          cycles = 0;

  cpu_top #(.imem_depth(64), .dmem_depth(cpu_model::dmem_words)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, what, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////
  // trace monitor
  //////////////////////////////
  always @(negedge clk) begin
    if (wb_valid === 1'b1) begin
      if (cpu_model::exp_wb.size() == 0) begin
        fail_run("a register writeback appeared that the model did not expect");
      end else begin
        check("writeback {reg, data}", 32'({wb_reg, wb_data}),
              32'(cpu_model::exp_wb.pop_front()));
      end
    end
    if (st_valid === 1'b1) begin
      if (cpu_model::exp_st.size() == 0) begin
        fail_run("a store appeared that the model did not expect");
      end else begin
        check("store {addr, data}", {st_addr, st_data}, cpu_model::exp_st.pop_front());
      end
    end
  end

  // starts and ends 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [15:0] data,
                          output logic [15:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word(input logic [11:0] addr, input logic [15:0] data,
                            input logic exp_err);
    logic [15:0] rdata;
    logic        err;

    apb_xfer(1'b1, addr, data, rdata, err);
    check($sformatf("pslverr on write to 0x%03h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic read_word(input logic [11:0] addr, input logic exp_err,
                           output logic [15:0] data);
    logic err;

    apb_xfer(1'b0, addr, 16'h0000, data, err);
    check($sformatf("pslverr on read of 0x%03h", addr), 32'(err), 32'(exp_err));
  endtask

  initial begin
    logic [15:0] rdata;

    void'($urandom(32'ha355_4a19));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    arst_n  = 1'b0;
    cpu_model::reset_model();
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    read_word(cpu_pkg::addr_ctrl, 1'b0, rdata);
    check("ctrl after reset", 32'(rdata), 32'd0);
    // unmapped and program-space reads
    read_word(12'h800, 1'b1, rdata);
    check("unmapped read data", 32'(rdata), 32'd0);
    read_word(12'h010, 1'b1, rdata);
    check("program word read data", 32'(rdata), 32'd0);

    for (int p = 0; p < n_progs; p++) begin
      cpu_model::make_program();
      for (int i = 0; i < cpu_model::prog_len; i++) begin
        write_word(12'(i * 4), cpu_model::prog[i], 1'b0);
      end
      write_word(cpu_pkg::addr_ctrl, 16'h0001, 1'b0);
      // program space is locked while running
      write_word(cpu_pkg::addr_prog_base, 16'hffff, 1'b1);

      rdata = '0;
      while (rdata[1] !== 1'b1) begin
        read_word(cpu_pkg::addr_ctrl, 1'b0, rdata);
      end
      check("run after halt", 32'(rdata[0]), 32'd0);
      read_word(cpu_pkg::addr_retired, 1'b0, rdata);
      check("retired count", 32'(rdata), 32'(cpu_model::exp_retired));
      check("writebacks still expected", 32'(cpu_model::exp_wb.size()), 32'd0);
      check("stores still expected", 32'(cpu_model::exp_st.size()), 32'd0);
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- vlog.f
hw/cpu_pkg.sv
hw/apb_ctrl.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_top.sv
tb/cpu_model.sv
tb/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module cpu_tb -f vlog.f -Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cpu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
